// ==== common/sf_params.svh ====
// video timing, scroll decode and width constants; single 6 MHz pixel clock, no PROM timing
`ifndef SF_PARAMS_SVH
`define SF_PARAMS_SVH

// ==============================
// line and frame timing
// ==============================
`define SF_H_TOTAL       384   // pixel clocks per line
`define SF_V_TOTAL       264   // lines per frame
`define SF_H_ACT_START   14
`define SF_H_ACT_END     270   // 256 visible columns
`define SF_HSYNC_START   300
`define SF_HSYNC_END     332
`define SF_V_ACT_START   16
`define SF_V_ACT_END     240   // 224 visible lines
`define SF_VSYNC_START   248
`define SF_VSYNC_END     252

// scroll registers in the cpu memory map
`define SF_ADDR_HSCRL_LO 16'hE800
`define SF_ADDR_HSCRL_HI 16'hE801   // bit 8 taken from data bit 0
`define SF_ADDR_VSCRL    16'hE802

// widths
`define SF_HPIX_W        9
`define SF_VPIX_W        8
`define SF_CNT_W         9     // raw counters, both directions
`define SF_COLOUR_W      8
`define SF_RGB_W         12
`define SF_CPU_ADDR_W    16
`define SF_CPU_DATA_W    8
`define SF_PAL_DEPTH     256

`endif

// ==== common/sf_video_pkg.sv ====
// video-side types; widths come from sf_params.svh, rgb is 4 bits per gun only
`include "sf_params.svh"

package sf_video_pkg;

	// ==============================
	// pixel coordinates
	// ==============================

	// screen column as seen by the layer renderers
	typedef logic [`SF_HPIX_W-1:0] hpix_t;

	// screen line, low 8 bits of the line counter
	typedef logic [`SF_VPIX_W-1:0] vpix_t;

	// raw counters, before flip
	typedef logic [`SF_CNT_W-1:0] hcnt_t;
	typedef logic [`SF_CNT_W-1:0] vcnt_t;

	// ==============================
	// colour
	// ==============================

	// layer pixel code, doubles as palette index
	typedef logic [`SF_COLOUR_W-1:0] colour_code_t;

	// red 11:8, green 7:4, blue 3:0
	typedef logic [`SF_RGB_W-1:0] rgb_t;

endpackage

// ==== common/sf_bus_pkg.sv ====
// cpu bus types for the memory-mapped video registers; write strobes only, no read path
`include "sf_params.svh"

package sf_bus_pkg;

	// ==============================
	// main cpu bus
	// ==============================

	// full z80 address, decoded exactly
	typedef logic [`SF_CPU_ADDR_W-1:0] cpu_addr_t;

	// write data, one byte per strobe
	typedef logic [`SF_CPU_DATA_W-1:0] cpu_data_t;

	// the palette port reuses the video types for address and data,
	// so only the cpu side lives here

endpackage

// ==== design/video_timing/video_timing.sv ====
// flip is sampled once after reset release and held; changing it later needs a new reset
`include "sf_params.svh"

module video_timing (
	input  logic                pixel_clk,
	input  logic                RESET_n,
	input  logic                flip_i,
	output sf_video_pkg::hpix_t hpix_o,
	output sf_video_pkg::vpix_t vpix_o,
	output logic                hsync_o,
	output logic                vsync_o,
	output logic                hblank_o,
	output logic                vblank_o
);

	sf_video_pkg::hcnt_t hcnt;
	sf_video_pkg::hcnt_t hcnt_nxt;
	sf_video_pkg::vcnt_t vcnt;
	sf_video_pkg::vcnt_t vcnt_nxt;

	logic flip_q;
	logic flip_taken;   // flip already sampled
	logic flip_eff;

	// ==============================
	// counters
	// ==============================

	always_comb begin
		hcnt_nxt = hcnt + 1'b1;
		vcnt_nxt = vcnt;
		if (hcnt == `SF_H_TOTAL - 1) begin
			hcnt_nxt = '0;
			if (vcnt == `SF_V_TOTAL - 1) begin
				vcnt_nxt = '0;
			end else begin
				vcnt_nxt = vcnt + 1'b1;   // advance on line wrap
			end
		end
	end

	// screen flip, taken from the level input on the first clock out of reset
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			flip_q     <= 1'b0;
			flip_taken <= 1'b0;
		end else if (!flip_taken) begin
			flip_q     <= flip_i;
			flip_taken <= 1'b1;
		end
	end

	// the very first step already follows the sampled value
	assign flip_eff = flip_taken ? flip_q : flip_i;

	// ==============================
	// registered outputs
	// ==============================

	// everything below is computed from the next count, so the
	// outputs move in the same cycle as the counters themselves
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			hcnt     <= '0;
			vcnt     <= '0;
			hpix_o   <= '0;
			vpix_o   <= '0;
			hsync_o  <= 1'b0;
			vsync_o  <= 1'b0;
			hblank_o <= 1'b1;   // count 0 is outside the active window
			vblank_o <= 1'b1;
		end else begin
			hcnt <= hcnt_nxt;
			vcnt <= vcnt_nxt;

			hpix_o <= flip_eff ? sf_video_pkg::hpix_t'(`SF_H_TOTAL - 1) - hcnt_nxt
			                   : hcnt_nxt;
			vpix_o <= flip_eff ? ~vcnt_nxt[`SF_VPIX_W-1:0]
			                   : vcnt_nxt[`SF_VPIX_W-1:0];

			hsync_o  <= (hcnt_nxt >= `SF_HSYNC_START) && (hcnt_nxt < `SF_HSYNC_END);
			vsync_o  <= (vcnt_nxt >= `SF_VSYNC_START) && (vcnt_nxt < `SF_VSYNC_END);
			hblank_o <= (hcnt_nxt < `SF_H_ACT_START) || (hcnt_nxt >= `SF_H_ACT_END);
			vblank_o <= (vcnt_nxt < `SF_V_ACT_START) || (vcnt_nxt >= `SF_V_ACT_END);
		end
	end

	// counters never leave their range
	a_hcnt_range: assert property (
		@(posedge pixel_clk) disable iff (!RESET_n)
		hcnt < `SF_H_TOTAL
	);

	a_vcnt_range: assert property (
		@(posedge pixel_clk) disable iff (!RESET_n)
		vcnt < `SF_V_TOTAL
	);

endmodule

// ==== design/scroll_regs.sv ====
// write-only scroll registers, exact 16-bit decode; sums wrap at 512 and 256
`include "sf_params.svh"

module scroll_regs (
	input  logic                  pixel_clk,
	input  logic                  RESET_n,
	input  sf_bus_pkg::cpu_addr_t cpu_addr_i,
	input  sf_bus_pkg::cpu_data_t cpu_data_i,
	input  logic                  cpu_wr_i,
	input  sf_video_pkg::hpix_t   hpix_i,
	input  sf_video_pkg::vpix_t   vpix_i,
	output sf_video_pkg::hpix_t   hpix_scrl_o,
	output sf_video_pkg::vpix_t   vpix_scrl_o
);

	logic sel_hlo;
	logic sel_hhi;
	logic sel_v;

	sf_video_pkg::hpix_t hscroll;   // 9 bits, two write addresses
	sf_video_pkg::vpix_t vscroll;

	// ==============================
	// address decode
	// ==============================

	assign sel_hlo = cpu_wr_i && (cpu_addr_i == `SF_ADDR_HSCRL_LO);
	assign sel_hhi = cpu_wr_i && (cpu_addr_i == `SF_ADDR_HSCRL_HI);
	assign sel_v   = cpu_wr_i && (cpu_addr_i == `SF_ADDR_VSCRL);

	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			hscroll <= '0;
			vscroll <= '0;
		end else begin
			if (sel_hlo) begin
				hscroll[7:0] <= cpu_data_i;
			end
			if (sel_hhi) begin
				hscroll[8] <= cpu_data_i[0];   // only bit 0 is wired
			end
			if (sel_v) begin
				vscroll <= cpu_data_i;
			end
		end
	end

	// ==============================
	// scrolled coordinates
	// ==============================

	// one cycle behind the pixel counters, carry out dropped
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			hpix_scrl_o <= '0;
			vpix_scrl_o <= '0;
		end else begin
			hpix_scrl_o <= hpix_i + hscroll;
			vpix_scrl_o <= vpix_i + vscroll;
		end
	end

	// decode must never select two registers for one strobe
	a_sel_onehot: assert property (
		@(posedge pixel_clk) disable iff (!RESET_n)
		$onehot0({sel_hlo, sel_hhi, sel_v})
	);

endmodule

// ==== design/colour_out/colour_mixer.sv ====
// two-stage pipe from layer codes to rgb; palette is loaded by the host, contents undefined until then
`include "sf_params.svh"

module colour_mixer (
	input  logic                       pixel_clk,
	input  logic                       RESET_n,
	input  sf_video_pkg::colour_code_t fg_px_i,
	input  sf_video_pkg::colour_code_t sp_px_i,
	input  sf_video_pkg::colour_code_t bg_px_i,
	input  logic                       blank_i,
	input  logic                       pal_wr_i,
	input  sf_video_pkg::colour_code_t pal_addr_i,
	input  sf_video_pkg::rgb_t         pal_data_i,
	output sf_video_pkg::rgb_t         rgb_o
);

	sf_video_pkg::colour_code_t code_sel;
	sf_video_pkg::colour_code_t code_q;
	logic                       blank_q;

	sf_video_pkg::rgb_t pal_mem [`SF_PAL_DEPTH];

	// ==============================
	// stage 1, layer priority
	// ==============================

	// foreground over sprites over background
	always_comb begin
		if (fg_px_i[1:0] != 2'b00) begin
			code_sel = fg_px_i;
		end else if (sp_px_i[3:0] != 4'h0) begin
			code_sel = sp_px_i;   // sprite pen 0 is transparent
		end else begin
			code_sel = bg_px_i;
		end
	end

	always_ff @(posedge pixel_clk) begin
		code_q <= code_sel;
	end

	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			blank_q <= 1'b1;
		end else begin
			blank_q <= blank_i;
		end
	end

	// ==============================
	// stage 2, palette lookup
	// ==============================

	// host write port, visible to lookups one cycle later
	always_ff @(posedge pixel_clk) begin
		if (pal_wr_i) begin
			pal_mem[pal_addr_i] <= pal_data_i;
		end
	end

	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			rgb_o <= '0;
		end else if (blank_q) begin
			rgb_o <= '0;   // black during blanking
		end else begin
			rgb_o <= pal_mem[code_q];
		end
	end

	// blank at the input must show up as black two pixels later
	a_blank_black: assert property (
		@(posedge pixel_clk) disable iff (!RESET_n)
		blank_i |-> ##2 (rgb_o == '0)
	);

endmodule

// ==== design/slapfight_video.sv ====
// video back end top; layer renderers are outside, their codes must match hpix_o of the same cycle
`include "sf_params.svh"

module slapfight_video (
	input  logic                       pixel_clk,
	input  logic                       RESET_n,
	input  logic                       flip_i,

	// cpu write strobe
	input  sf_bus_pkg::cpu_addr_t      cpu_addr_i,
	input  sf_bus_pkg::cpu_data_t      cpu_data_i,
	input  logic                       cpu_wr_i,

	// layer pixel codes
	input  sf_video_pkg::colour_code_t fg_px_i,
	input  sf_video_pkg::colour_code_t sp_px_i,
	input  sf_video_pkg::colour_code_t bg_px_i,

	// palette load port
	input  logic                       pal_wr_i,
	input  sf_video_pkg::colour_code_t pal_addr_i,
	input  sf_video_pkg::rgb_t         pal_data_i,

	output sf_video_pkg::hpix_t        hpix_o,
	output sf_video_pkg::vpix_t        vpix_o,
	output sf_video_pkg::hpix_t        hpix_scrl_o,
	output sf_video_pkg::vpix_t        vpix_scrl_o,
	output logic                       hsync_o,
	output logic                       vsync_o,
	output logic                       hblank_o,
	output logic                       vblank_o,
	output sf_video_pkg::rgb_t         rgb_o
);

	logic blank;

	// ==============================
	// timing and scroll
	// ==============================

	video_timing i_video_timing (
		.pixel_clk (pixel_clk),
		.RESET_n   (RESET_n),
		.flip_i    (flip_i),
		.hpix_o    (hpix_o),
		.vpix_o    (vpix_o),
		.hsync_o   (hsync_o),
		.vsync_o   (vsync_o),
		.hblank_o  (hblank_o),
		.vblank_o  (vblank_o)
	);

	scroll_regs i_scroll_regs (
		.pixel_clk   (pixel_clk),
		.RESET_n     (RESET_n),
		.cpu_addr_i  (cpu_addr_i),
		.cpu_data_i  (cpu_data_i),
		.cpu_wr_i    (cpu_wr_i),
		.hpix_i      (hpix_o),
		.vpix_i      (vpix_o),
		.hpix_scrl_o (hpix_scrl_o),
		.vpix_scrl_o (vpix_scrl_o)
	);

	assign blank = hblank_o | vblank_o;   // either direction blanks the pixel

	colour_mixer i_colour_mixer (
		.pixel_clk  (pixel_clk),
		.RESET_n    (RESET_n),
		.fg_px_i    (fg_px_i),
		.sp_px_i    (sp_px_i),
		.bg_px_i    (bg_px_i),
		.blank_i    (blank),
		.pal_wr_i   (pal_wr_i),
		.pal_addr_i (pal_addr_i),
		.pal_data_i (pal_data_i),
		.rgb_o      (rgb_o)
	);

endmodule

// ==== dv/tb_slapfight_video.sv ====
// flip is only sampled out of reset, so the flip test runs after a second reset; palette must be loaded before mixing
`include "sf_params.svh"

module tb_slapfight_video;

	localparam int FRAME_CYC  = `SF_H_TOTAL * `SF_V_TOTAL;
	localparam int WATCHDOG_T = 4 * FRAME_CYC * 10;   // four frames at period 10

	logic                       pixel_clk;
	logic                       RESET_n;
	logic                       flip_i;
	sf_bus_pkg::cpu_addr_t      cpu_addr_i;
	sf_bus_pkg::cpu_data_t      cpu_data_i;
	logic                       cpu_wr_i;
	sf_video_pkg::colour_code_t fg_px_i;
	sf_video_pkg::colour_code_t sp_px_i;
	sf_video_pkg::colour_code_t bg_px_i;
	logic                       pal_wr_i;
	sf_video_pkg::colour_code_t pal_addr_i;
	sf_video_pkg::rgb_t         pal_data_i;
	sf_video_pkg::hpix_t        hpix_o;
	sf_video_pkg::vpix_t        vpix_o;
	sf_video_pkg::hpix_t        hpix_scrl_o;
	sf_video_pkg::vpix_t        vpix_scrl_o;
	logic                       hsync_o;
	logic                       vsync_o;
	logic                       hblank_o;
	logic                       vblank_o;
	sf_video_pkg::rgb_t         rgb_o;

	// reference model
	sf_video_pkg::hcnt_t        h_cnt;
	sf_video_pkg::vcnt_t        v_cnt;
	sf_video_pkg::hpix_t        exp_hpix;
	sf_video_pkg::vpix_t        exp_vpix;
	sf_video_pkg::hpix_t        exp_hscrl;
	sf_video_pkg::vpix_t        exp_vscrl;
	sf_video_pkg::hpix_t        m_hscroll;
	sf_video_pkg::vpix_t        m_vscroll;
	sf_video_pkg::colour_code_t exp_code;
	sf_video_pkg::rgb_t         m_pal [`SF_PAL_DEPTH];
	sf_video_pkg::rgb_t         rgb_d1;
	sf_video_pkg::rgb_t         exp_rgb;
	logic                       exp_hblank;
	logic                       exp_vblank;
	logic [1:0]                 mix_d;
	logic                       flip_mode;
	logic                       mix_on;
	logic                       armed;   // one clock past reset release

	// sync measurement
	logic hsync_d;
	logic vsync_d;
	int   hs_gap;
	int   hs_width;
	int   hs_rises;
	int   vs_gap;
	int   vs_rises;

	int err [1:5] = '{default: 0};
	int kind_seen [0:2] = '{default: 0};

	slapfight_video i_slapfight_video (.*);

	initial pixel_clk = 1'b0;
	always #5 pixel_clk = ~pixel_clk;

	// ==============================
	// reference model
	// ==============================

	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (h_cnt == `SF_H_TOTAL - 1) begin
			h_cnt <= '0;
			v_cnt <= (v_cnt == `SF_V_TOTAL - 1) ? '0 : v_cnt + 1'b1;
		end else begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	// flip only takes hold from the first clock after release
	assign exp_hpix   = (flip_mode && armed) ? sf_video_pkg::hpix_t'(`SF_H_TOTAL - 1 - h_cnt)
	                                         : h_cnt;
	assign exp_vpix   = (flip_mode && armed) ? ~v_cnt[7:0] : v_cnt[7:0];
	assign exp_hblank = (h_cnt < `SF_H_ACT_START) || (h_cnt >= `SF_H_ACT_END);
	assign exp_vblank = (v_cnt < `SF_V_ACT_START) || (v_cnt >= `SF_V_ACT_END);

	// fg over sprites over bg
	assign exp_code = (fg_px_i[1:0] != 2'b00) ? fg_px_i :
	                  (sp_px_i[3:0] != 4'h0)  ? sp_px_i : bg_px_i;

	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			armed     <= 1'b0;
			m_hscroll <= '0;
			m_vscroll <= '0;
			exp_hscrl <= '0;
			exp_vscrl <= '0;
			mix_d     <= '0;
		end else begin
			armed <= 1'b1;
			if (cpu_wr_i && cpu_addr_i == `SF_ADDR_HSCRL_LO) m_hscroll[7:0] <= cpu_data_i;
			if (cpu_wr_i && cpu_addr_i == `SF_ADDR_HSCRL_HI) m_hscroll[8] <= cpu_data_i[0];
			if (cpu_wr_i && cpu_addr_i == `SF_ADDR_VSCRL) m_vscroll <= cpu_data_i;
			exp_hscrl <= exp_hpix + m_hscroll;   // wraps at 512
			exp_vscrl <= exp_vpix + m_vscroll;
			rgb_d1    <= (exp_hblank || exp_vblank) ? '0 : m_pal[exp_code];
			exp_rgb   <= rgb_d1;
			mix_d     <= {mix_d[0], mix_on};
		end
	end

	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			hsync_d  <= 1'b0;
			vsync_d  <= 1'b0;
			hs_gap   <= 0;
			hs_width <= 0;
			hs_rises <= 0;
			vs_gap   <= 0;
			vs_rises <= 0;
		end else begin
			hsync_d  <= hsync_o;
			vsync_d  <= vsync_o;
			hs_gap   <= (hsync_o && !hsync_d) ? 1 : hs_gap + 1;
			vs_gap   <= (vsync_o && !vsync_d) ? 1 : vs_gap + 1;
			hs_width <= hsync_o ? hs_width + 1 : 0;
			hs_rises <= hs_rises + int'(hsync_o && !hsync_d);
			vs_rises <= vs_rises + int'(vsync_o && !vsync_d);
		end
	end

	// ==============================
	// checks
	// ==============================

	a_hs_period: assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		(hsync_o && !hsync_d && hs_rises > 0) |-> hs_gap == `SF_H_TOTAL) else begin
		err[1]++;
		$display("** Error hsync_o period %h, expected %h", $sampled(hs_gap), `SF_H_TOTAL);
	end
	a_hs_width: assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		(!hsync_o && hsync_d) |-> hs_width == `SF_HSYNC_END - `SF_HSYNC_START) else begin
		err[1]++;
		$display("** Error hsync_o width %h, expected %h", $sampled(hs_width), 32);
	end
	a_vs_period: assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		(vsync_o && !vsync_d && vs_rises > 0) |-> vs_gap == FRAME_CYC) else begin
		err[1]++;
		$display("** Error vsync_o period %h, expected %h", $sampled(vs_gap), FRAME_CYC);
	end
	a_hblank: assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		hblank_o == exp_hblank) else begin
		err[2]++;
		$display("** Error hblank_o %h, expected %h", $sampled(hblank_o), $sampled(exp_hblank));
	end
	a_vblank: assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		vblank_o == exp_vblank) else begin
		err[2]++;
		$display("** Error vblank_o %h, expected %h", $sampled(vblank_o), $sampled(exp_vblank));
	end
	a_hpix: assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		hpix_o == exp_hpix) else begin
		err[3]++;
		$display("** Error hpix_o %h, expected %h", $sampled(hpix_o), $sampled(exp_hpix));
	end
	a_vpix: assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		vpix_o == exp_vpix) else begin
		err[3]++;
		$display("** Error vpix_o %h, expected %h", $sampled(vpix_o), $sampled(exp_vpix));
	end
	a_hscrl: assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		armed |-> hpix_scrl_o == exp_hscrl) else begin
		err[4]++;
		$display("** Error hpix_scrl_o %h, expected %h", $sampled(hpix_scrl_o), $sampled(exp_hscrl));
	end
	a_vscrl: assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		armed |-> vpix_scrl_o == exp_vscrl) else begin
		err[4]++;
		$display("** Error vpix_scrl_o %h, expected %h", $sampled(vpix_scrl_o), $sampled(exp_vscrl));
	end
	a_rgb: assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		mix_d[1] |-> rgb_o == exp_rgb) else begin
		err[5]++;
		$display("** Error rgb_o %h, expected %h", $sampled(rgb_o), $sampled(exp_rgb));
	end

	// ==============================
	// stimulus
	// ==============================

	task automatic apply_reset(input logic flip);
		RESET_n   = 1'b0;
		flip_i    = flip;   // held through reset and after
		flip_mode = flip;
		repeat (3) @(negedge pixel_clk);
		RESET_n = 1'b1;
	endtask

	task automatic load_palette();
		sf_video_pkg::rgb_t val;
		for (int a = 0; a < `SF_PAL_DEPTH; a++) begin
			val        = sf_video_pkg::rgb_t'($urandom);
			m_pal[a]   = val;
			pal_wr_i   = 1'b1;
			pal_addr_i = sf_video_pkg::colour_code_t'(a);
			pal_data_i = val;
			@(negedge pixel_clk);
		end
		pal_wr_i = 1'b0;
	endtask

	// kind 0 fg wins, 1 sprite wins, 2 bg shows through
	task automatic drive_layer_codes(input int kind);
		sf_video_pkg::colour_code_t fg;
		sf_video_pkg::colour_code_t sp;
		fg = sf_video_pkg::colour_code_t'($urandom);
		sp = sf_video_pkg::colour_code_t'($urandom);
		if (kind == 0 && fg[1:0] == 2'b00) fg[0] = 1'b1;
		if (kind != 0) fg[1:0] = 2'b00;
		if (kind == 1 && sp[3:0] == 4'h0) sp[2] = 1'b1;
		if (kind == 2) sp[3:0] = 4'h0;
		fg_px_i = fg;
		sp_px_i = sp;
		bg_px_i = sf_video_pkg::colour_code_t'($urandom);
		kind_seen[kind]++;
		@(negedge pixel_clk);
	endtask

	task automatic write_cpu(input sf_bus_pkg::cpu_addr_t addr, input sf_bus_pkg::cpu_data_t data);
		cpu_addr_i = addr;
		cpu_data_i = data;
		cpu_wr_i   = 1'b1;
		@(negedge pixel_clk);
		cpu_wr_i = 1'b0;
	endtask

	task automatic report_test(input int id, input string name);
		if (err[id] == 0) $display("test %0d %s: passed", id, name);
		else $display("test %0d %s: failed, %0d errors", id, name, err[id]);
	endtask

	initial begin
		int n;
		int total;
		int bad;
		void'($urandom(32'h3bf10c99));
		{cpu_addr_i, cpu_data_i, cpu_wr_i} = '0;
		{fg_px_i, sp_px_i, bg_px_i} = '0;
		{pal_wr_i, pal_addr_i, pal_data_i} = '0;
		mix_on = 1'b0;
		apply_reset(1'b0);

		load_palette();
		n = 0;
		while (exp_vblank && n < FRAME_CYC) begin   // mix inside the visible lines
			@(negedge pixel_clk);
			n++;
		end
		mix_on = 1'b1;
		repeat (2 * `SF_H_TOTAL) drive_layer_codes($urandom_range(2, 0));
		mix_on = 1'b0;
		repeat (3) @(negedge pixel_clk);
		foreach (kind_seen[k]) if (kind_seen[k] == 0) begin
			$display("priority case %0d was never driven", k);
			err[5]++;
		end
		report_test(5, "priority and palette");

		repeat (60) begin
			case ($urandom_range(4, 0))
				0: write_cpu(`SF_ADDR_HSCRL_LO, $urandom);
				1: write_cpu(`SF_ADDR_HSCRL_HI, $urandom);
				2: write_cpu(`SF_ADDR_VSCRL, $urandom);
				3: write_cpu(`SF_ADDR_VSCRL + 16'h1, $urandom);   // neighbour, ignored
				default: write_cpu(`SF_ADDR_HSCRL_LO - 16'h1, $urandom);
			endcase
			repeat ($urandom_range(3, 0)) @(negedge pixel_clk);
		end
		repeat (4) @(negedge pixel_clk);
		report_test(4, "scroll registers");

		n = 0;
		while (vs_rises < 2 && n < 2 * FRAME_CYC) begin
			@(negedge pixel_clk);
			n++;
		end
		if (vs_rises < 2) begin
			$display("vsync_o did not pulse twice within two frames");
			err[1]++;
		end
		report_test(1, "line and frame timing");
		report_test(2, "blanking");

		apply_reset(1'b1);
		repeat (3 * `SF_H_TOTAL) @(negedge pixel_clk);
		report_test(3, "screen flip");

		total = 0;
		bad   = 0;
		foreach (err[i]) begin
			total += err[i];
			bad   += int'(err[i] != 0);
		end
		$display("tests passed %0d, failed %0d, errors %0d", 5 - bad, bad, total);
		if (total == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	// watchdog, four frames cover every test with margin
	initial begin
		#(WATCHDOG_T);
		$display("watchdog expired after %0d time units, run did not finish", WATCHDOG_T);
		$display("TEST FAIL");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+common
common/sf_video_pkg.sv
common/sf_bus_pkg.sv
design/video_timing/video_timing.sv
design/scroll_regs.sv
design/colour_out/colour_mixer.sv
design/slapfight_video.sv
dv/tb_slapfight_video.sv

// ==== Bender.yml ====
package:
  name: slapfight_video

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/sf_video_pkg.sv
      - common/sf_bus_pkg.sv
      - design/video_timing/video_timing.sv
      - design/scroll_regs.sv
      - design/colour_out/colour_mixer.sv
      - design/slapfight_video.sv

  - target: test
    include_dirs:
      - common
    files:
      - dv/tb_slapfight_video.sv
